// ==== logic/mul_pkg.sv ====
// Unsigned 32x32 operands only; MUL_LATENCY must be edited by hand whenever MUL_PIPE_MASK changes.
package mul_pkg;

  // Datapath sizes.
  localparam int unsigned MUL_WIDTH      = 32;
  localparam int unsigned MUL_PROD_WIDTH = 64;
  localparam int unsigned MUL_ROWS       = 31;  // One adder row per multiplier bit above bit 0.

  // A set bit places a register after that row of the array.
  localparam logic [MUL_ROWS-1:0] MUL_PIPE_MASK = 31'h0888_8888;

  // Cycles from valid in to valid out of the array, equal to the set bits of the mask.
  localparam int unsigned MUL_LATENCY = 7;

  // Bus widths.
  localparam int unsigned WB_ADDR_WIDTH = 5;
  localparam int unsigned WB_DATA_WIDTH = 32;

  // Register map in byte addresses.
  localparam logic [WB_ADDR_WIDTH-1:0] REG_OPA     = 5'h00;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_OPB     = 5'h04;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL    = 5'h08;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_PROD_LO = 5'h0C;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_PROD_HI = 5'h10;

  // Control bit on write, status bits on read of REG_CTRL.
  localparam int unsigned CTRL_START_BIT = 0;
  localparam int unsigned STAT_BUSY_BIT  = 0;
  localparam int unsigned STAT_DONE_BIT  = 1;

  // The product as the array delivers it, or as the two words the bus returns.
  typedef union packed {
    logic [MUL_PROD_WIDTH-1:0] full;
    struct packed {
      logic [WB_DATA_WIDTH-1:0] hi;
      logic [WB_DATA_WIDTH-1:0] lo;
    } halves;
  } mul_prod_u;

endpackage

// ==== logic/mul_array_row.sv ====
// No back-pressure; a registered row updates on every clock, so its input must be consumed as presented.
`timescale 1ns/1ps

module mul_array_row #(
  parameter int unsigned row_idx_p  = 0,
  parameter bit          pipeline_p = 1'b0
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             v_i,
  input  logic [mul_pkg::MUL_WIDTH-1:0]    a_i,
  input  logic [mul_pkg::MUL_WIDTH-1:0]    b_i,
  input  logic [mul_pkg::MUL_WIDTH-1:0]    s_i,
  input  logic                             c_i,
  input  logic [row_idx_p:0]               prod_accum_i,
  output logic                             v_o,
  output logic [mul_pkg::MUL_WIDTH-1:0]    a_o,
  output logic [mul_pkg::MUL_WIDTH-1:0]    b_o,
  output logic [mul_pkg::MUL_WIDTH-1:0]    s_o,
  output logic                             c_o,
  output logic [row_idx_p+1:0]             prod_accum_o
);
  import mul_pkg::*;

  logic [MUL_WIDTH-1:0] pp;      // Partial product of this row.
  logic [MUL_WIDTH-1:0] addend;  // Previous sum shifted down by the bit already retired.
  logic [MUL_WIDTH-1:0] sum;
  logic [MUL_WIDTH:0]   carry;

  assign pp     = a_i & {MUL_WIDTH{b_i[row_idx_p+1]}};
  assign addend = {c_i, s_i[MUL_WIDTH-1:1]};

  // Ripple-carry adder with one full adder per bit.
  always_comb begin
    carry[0] = 1'b0;
    for (int k = 0; k < MUL_WIDTH; k++) begin
      sum[k]     = pp[k] ^ addend[k] ^ carry[k];
      carry[k+1] = (pp[k] & addend[k]) | (carry[k] & (pp[k] ^ addend[k]));
    end
  end

  if (pipeline_p) begin : g_reg
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        v_o <= 1'b0;
      end else begin
        v_o <= v_i;
      end
    end

    always_ff @(posedge clk_i) begin
      a_o          <= a_i;
      b_o          <= b_i;
      s_o          <= sum;
      c_o          <= carry[MUL_WIDTH];
      prod_accum_o <= {sum[0], prod_accum_i};  // Lowest sum bit is final.
    end
  end else begin : g_comb
    assign v_o          = v_i;
    assign a_o          = a_i;
    assign b_o          = b_i;
    assign s_o          = sum;
    assign c_o          = carry[MUL_WIDTH];
    assign prod_accum_o = {sum[0], prod_accum_i};
  end

endmodule

// ==== logic/mul_array.sv ====
// Latency is set by MUL_PIPE_MASK in mul_pkg; an all-zero mask gives a purely combinational multiplier.
`timescale 1ns/1ps

module mul_array (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              v_i,
  input  logic [mul_pkg::MUL_WIDTH-1:0]     a_i,
  input  logic [mul_pkg::MUL_WIDTH-1:0]     b_i,
  output logic                              v_o,
  output logic [mul_pkg::MUL_PROD_WIDTH-1:0] prod_o
);
  import mul_pkg::*;

  // Chain between rows. Entry i feeds row i, entry i+1 is driven by row i.
  logic [MUL_WIDTH-1:0] a_c   [0:MUL_ROWS-1];
  logic [MUL_WIDTH-1:0] b_c   [0:MUL_ROWS-1];
  logic [MUL_WIDTH-1:0] s_c   [0:MUL_ROWS];
  logic                 c_c   [0:MUL_ROWS];
  logic                 v_c   [0:MUL_ROWS];
  logic [MUL_WIDTH-1:0] acc_c [0:MUL_ROWS];  // Entry i holds i+1 valid low bits.

  logic [MUL_WIDTH-1:0] pp0;

  // Partial product of b_i bit 0 seeds the running sum.
  assign pp0 = a_i & {MUL_WIDTH{b_i[0]}};

  assign a_c[0]   = a_i;
  assign b_c[0]   = b_i;
  assign s_c[0]   = pp0;
  assign c_c[0]   = 1'b0;
  assign v_c[0]   = v_i;
  assign acc_c[0] = {{(MUL_WIDTH-1){1'b0}}, pp0[0]};

  for (genvar i = 0; i < MUL_ROWS; i++) begin : g_row
    if (i < MUL_ROWS-1) begin : g_mid
      mul_array_row #(
        .row_idx_p (i),
        .pipeline_p(MUL_PIPE_MASK[i])
      ) i_row (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .v_i         (v_c[i]),
        .a_i         (a_c[i]),
        .b_i         (b_c[i]),
        .s_i         (s_c[i]),
        .c_i         (c_c[i]),
        .prod_accum_i(acc_c[i][i:0]),
        .v_o         (v_c[i+1]),
        .a_o         (a_c[i+1]),
        .b_o         (b_c[i+1]),
        .s_o         (s_c[i+1]),
        .c_o         (c_c[i+1]),
        .prod_accum_o(acc_c[i+1][i+1:0])
      );
    end else begin : g_last
      // Operands are not needed past the last row.
      mul_array_row #(
        .row_idx_p (i),
        .pipeline_p(MUL_PIPE_MASK[i])
      ) i_row (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .v_i         (v_c[i]),
        .a_i         (a_c[i]),
        .b_i         (b_c[i]),
        .s_i         (s_c[i]),
        .c_i         (c_c[i]),
        .prod_accum_i(acc_c[i][i:0]),
        .v_o         (v_c[i+1]),
        .a_o         (),
        .b_o         (),
        .s_o         (s_c[i+1]),
        .c_o         (c_c[i+1]),
        .prod_accum_o(acc_c[i+1])
      );
    end
  end

  // Bit 0 of the final sum is already the top bit of the accumulated low word.
  assign prod_o = {c_c[MUL_ROWS], s_c[MUL_ROWS][MUL_WIDTH-1:1], acc_c[MUL_ROWS]};
  assign v_o    = v_c[MUL_ROWS];

endmodule

// ==== logic/wb_mul_regs.sv ====
// Wishbone classic slave, full-word accesses only (sel ignored), no error or retry, one multiply at a time.
`timescale 1ns/1ps

module wb_mul_regs (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [mul_pkg::WB_ADDR_WIDTH-1:0]   wb_adr_i,
  input  logic [mul_pkg::WB_DATA_WIDTH-1:0]   wb_dat_i,
  input  logic [mul_pkg::WB_DATA_WIDTH/8-1:0] wb_sel_i,  // Every access is a full word.
  output logic [mul_pkg::WB_DATA_WIDTH-1:0]   wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                mul_v_o,
  output logic [mul_pkg::MUL_WIDTH-1:0]       mul_a_o,
  output logic [mul_pkg::MUL_WIDTH-1:0]       mul_b_o,
  input  logic                                mul_v_i,
  input  logic [mul_pkg::MUL_PROD_WIDTH-1:0]  mul_prod_i
);
  import mul_pkg::*;

  logic                     req;        // New request, not yet answered.
  logic                     wr_en;
  logic                     start_acc;
  logic [MUL_WIDTH-1:0]     opa_q;
  logic [MUL_WIDTH-1:0]     opb_q;
  logic                     busy_q;
  logic                     done_q;
  logic                     mul_v_q;
  mul_prod_u                prod_q;
  logic [WB_DATA_WIDTH-1:0] stat_word;
  logic [WB_DATA_WIDTH-1:0] rd_data;

  // The ack term keeps a held request from being answered twice.
  assign req   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en = req & wb_we_i;

  // A start is only taken while the array is idle.
  assign start_acc = wr_en && (wb_adr_i == REG_CTRL) && wb_dat_i[CTRL_START_BIT] && !busy_q;

  always_comb begin
    stat_word                = '0;
    stat_word[STAT_BUSY_BIT] = busy_q;
    stat_word[STAT_DONE_BIT] = done_q;
  end

  always_comb begin
    case (wb_adr_i)
      REG_OPA:     rd_data = opa_q;
      REG_OPB:     rd_data = opb_q;
      REG_CTRL:    rd_data = stat_word;
      REG_PROD_LO: rd_data = prod_q.halves.lo;
      REG_PROD_HI: rd_data = prod_q.halves.hi;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;  // Single-cycle ack.
    end
  end

  // Read data is captured with the ack, so it holds while ack is high.
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  // Operands stay fixed while a multiply is in flight.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      opa_q <= '0;
      opb_q <= '0;
    end else if (wr_en && !busy_q) begin
      if (wb_adr_i == REG_OPA) begin
        opa_q <= wb_dat_i;
      end
      if (wb_adr_i == REG_OPB) begin
        opb_q <= wb_dat_i;
      end
    end
  end

  // Multiply sequence. A start clears done, the returning valid sets it.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      mul_v_q <= 1'b0;
    end else begin
      mul_v_q <= start_acc;
      if (start_acc) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (busy_q && mul_v_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prod_q.full <= '0;
    end else if (busy_q && mul_v_i) begin
      prod_q.full <= mul_prod_i;
    end
  end

  assign mul_v_o = mul_v_q;
  assign mul_a_o = opa_q;
  assign mul_b_o = opb_q;

endmodule

// ==== logic/wb_mul_top.sv ====
// Wishbone classic multiplier; done follows an accepted start by MUL_LATENCY + 2 cycles.
`timescale 1ns/1ps

module wb_mul_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [mul_pkg::WB_ADDR_WIDTH-1:0]   wb_adr_i,
  input  logic [mul_pkg::WB_DATA_WIDTH-1:0]   wb_dat_i,
  input  logic [mul_pkg::WB_DATA_WIDTH/8-1:0] wb_sel_i,
  output logic [mul_pkg::WB_DATA_WIDTH-1:0]   wb_dat_o,
  output logic                                wb_ack_o
);
  import mul_pkg::*;

  logic                      mul_v_req;
  logic [MUL_WIDTH-1:0]      mul_a;
  logic [MUL_WIDTH-1:0]      mul_b;
  logic                      mul_v_rsp;
  logic [MUL_PROD_WIDTH-1:0] mul_prod;

  wb_mul_regs i_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .mul_v_o   (mul_v_req),
    .mul_a_o   (mul_a),
    .mul_b_o   (mul_b),
    .mul_v_i   (mul_v_rsp),
    .mul_prod_i(mul_prod)
  );

  mul_array i_array (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (mul_v_req),
    .a_i    (mul_a),
    .b_i    (mul_b),
    .v_o    (mul_v_rsp),
    .prod_o (mul_prod)
  );

endmodule

// ==== test/tb_wb_mul.sv ====
// Assumes the default pipeline mask, so a status read a few cycles after a start still sees busy.
`timescale 1ns/1ps

module tb_wb_mul;
  import mul_pkg::*;

  localparam int unsigned NUM_FIXED   = 8;
  localparam int unsigned NUM_RAND    = 12;
  localparam int unsigned NUM_ENTRIES = NUM_FIXED + NUM_RAND;
  localparam int unsigned ACK_TIMEOUT = 16;  // Cycles one access may wait for ack.
  localparam int unsigned POLL_LIMIT  = 64;  // Status reads before a multiply counts as stuck.

  // Status and control words as the register map defines them.
  localparam logic [WB_DATA_WIDTH-1:0] START_WORD = 32'h1 << CTRL_START_BIT;
  localparam logic [WB_DATA_WIDTH-1:0] BUSY_WORD  = 32'h1 << STAT_BUSY_BIT;
  localparam logic [WB_DATA_WIDTH-1:0] DONE_WORD  = 32'h1 << STAT_DONE_BIT;

  logic                       clk;
  logic                       reset;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [WB_ADDR_WIDTH-1:0]   wb_adr;
  logic [WB_DATA_WIDTH-1:0]   wb_dat_wr;
  logic [WB_DATA_WIDTH/8-1:0] wb_sel;
  logic [WB_DATA_WIDTH-1:0]   wb_dat_rd;
  logic                       wb_ack;
  logic [31:0]                lfsr_q;

  // Stimulus table. Expected products are filled in beside the operands.
  logic [MUL_WIDTH-1:0]      op_a_tab [0:NUM_ENTRIES-1];
  logic [MUL_WIDTH-1:0]      op_b_tab [0:NUM_ENTRIES-1];
  logic [MUL_PROD_WIDTH-1:0] exp_tab  [0:NUM_ENTRIES-1];

  wb_mul_top i_dut (
    .clk_i   (clk),
    .reset_i (reset),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i (wb_we),
    .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_wr),
    .wb_sel_i(wb_sel),
    .wb_dat_o(wb_dat_rd),
    .wb_ack_o(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];  // Taps of x^32 + x^22 + x^2 + x + 1.
    return {state[30:0], fb};
  endfunction

  // One LFSR step per bit of the word.
  task automatic draw_word(output logic [31:0] word);
    word = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      word   = {word[30:0], lfsr_q[0]};
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Simulation stopped after an error.");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Fail at time %0t: %s expected 0x%h, got 0x%h",
                                $time, name, expected, actual));
    end
  endtask

  // One classic cycle. Inputs change on the falling edge, ack is sampled there too.
  task automatic bus_access(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                            input logic [WB_DATA_WIDTH-1:0] wdat,
                            output logic [WB_DATA_WIDTH-1:0] rdat);
    int cycles;
    cycles = 0;
    @(negedge clk);
    check_value("wb_ack before request", 1'b0, wb_ack);  // The previous ack lasts one cycle.
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = adr;
    wb_dat_wr = wdat;
    wb_sel    = '1;
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!wb_ack) begin
      stop_with_error($sformatf("No ack from the slave for an access to address 0x%02h.", adr));
    end
    rdat   = wb_dat_rd;  // Valid while ack is high.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [WB_ADDR_WIDTH-1:0] adr,
                           input logic [WB_DATA_WIDTH-1:0] dat);
    logic [WB_DATA_WIDTH-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input logic [WB_ADDR_WIDTH-1:0] adr,
                          output logic [WB_DATA_WIDTH-1:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic start_multiply(input logic [MUL_WIDTH-1:0] a, input logic [MUL_WIDTH-1:0] b);
    write_reg(REG_OPA, a);
    write_reg(REG_OPB, b);
    write_reg(REG_CTRL, START_WORD);
  endtask

  // Polls the status word until done is set; busy must be clear by then.
  task automatic wait_done();
    logic [WB_DATA_WIDTH-1:0] status;
    int polls;
    polls  = 0;
    status = '0;
    while (!status[STAT_DONE_BIT] && polls < POLL_LIMIT) begin
      read_reg(REG_CTRL, status);
      polls++;
    end
    if (!status[STAT_DONE_BIT]) begin
      stop_with_error("The multiplier never reported done.");
    end
    check_value("status at done", DONE_WORD, status);
  endtask

  task automatic check_product(input logic [MUL_PROD_WIDTH-1:0] expected);
    logic [WB_DATA_WIDTH-1:0] rdata;
    read_reg(REG_PROD_LO, rdata);
    check_value("prod_lo", expected[31:0], rdata);
    read_reg(REG_PROD_HI, rdata);
    check_value("prod_hi", expected[63:32], rdata);
  endtask

  task automatic fill_table();
    op_a_tab[0] = 32'h0000_0000;
    op_b_tab[0] = 32'h1234_5678;
    op_a_tab[1] = 32'hdead_beef;
    op_b_tab[1] = 32'h0000_0000;
    op_a_tab[2] = 32'h0000_0001;
    op_b_tab[2] = 32'hcafe_f00d;
    op_a_tab[3] = 32'h8765_4321;
    op_b_tab[3] = 32'h0000_0001;
    op_a_tab[4] = 32'hffff_ffff;
    op_b_tab[4] = 32'hffff_ffff;
    op_a_tab[5] = 32'h8000_0000;
    op_b_tab[5] = 32'h8000_0000;
    op_a_tab[6] = 32'h0001_0000;
    op_b_tab[6] = 32'h0001_0000;
    op_a_tab[7] = 32'h0000_0400;
    op_b_tab[7] = 32'h0020_0000;
    for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
      draw_word(op_a_tab[i]);
      draw_word(op_b_tab[i]);
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      exp_tab[i] = {32'h0, op_a_tab[i]} * {32'h0, op_b_tab[i]};  // Unsigned 64-bit product.
    end
  endtask

  initial begin
    logic [WB_DATA_WIDTH-1:0]  rdata;
    logic [MUL_WIDTH-1:0]      a_keep;
    logic [MUL_WIDTH-1:0]      b_keep;
    logic [MUL_PROD_WIDTH-1:0] p_keep;

    reset     = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_wr = '0;
    wb_sel    = '0;
    lfsr_q    = 32'h0eb4_0e52;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    fill_table();

    // Every mapped register starts at zero, and so does the status word.
    for (int r = 0; r <= REG_PROD_HI; r += 4) begin
      read_reg(r[WB_ADDR_WIDTH-1:0], rdata);
      check_value($sformatf("reg 0x%02h after reset", r), 0, rdata);
    end

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      start_multiply(op_a_tab[i], op_b_tab[i]);
      wait_done();
      check_product(exp_tab[i]);
    end

    // Operand writes during a multiply must not reach the registers.
    a_keep = 32'h1357_9bdf;
    b_keep = 32'h2468_ace0;
    p_keep = {32'h0, a_keep} * {32'h0, b_keep};
    start_multiply(a_keep, b_keep);
    write_reg(REG_OPA, ~a_keep);
    write_reg(REG_OPB, ~b_keep);
    read_reg(REG_OPA, rdata);
    check_value("opa while busy", a_keep, rdata);
    read_reg(REG_OPB, rdata);
    check_value("opb while busy", b_keep, rdata);
    wait_done();
    check_product(p_keep);
    read_reg(REG_OPA, rdata);
    check_value("opa after done", a_keep, rdata);
    read_reg(REG_OPB, rdata);
    check_value("opb after done", b_keep, rdata);

    // A second start while busy is dropped, and a later start clears done.
    draw_word(a_keep);
    draw_word(b_keep);
    p_keep = {32'h0, a_keep} * {32'h0, b_keep};
    start_multiply(a_keep, b_keep);
    write_reg(REG_CTRL, START_WORD);
    read_reg(REG_CTRL, rdata);
    check_value("status after start while busy", BUSY_WORD, rdata);
    wait_done();
    check_product(p_keep);
    draw_word(a_keep);
    draw_word(b_keep);
    p_keep = {32'h0, a_keep} * {32'h0, b_keep};
    start_multiply(a_keep, b_keep);
    read_reg(REG_CTRL, rdata);
    check_value("status after restart", BUSY_WORD, rdata);
    wait_done();
    check_product(p_keep);

    // Unmapped addresses and the product words take no writes.
    for (int r = REG_PROD_HI + 4; r < 32; r += 4) begin
      write_reg(r[WB_ADDR_WIDTH-1:0], 32'hffff_ffff);
      read_reg(r[WB_ADDR_WIDTH-1:0], rdata);
      check_value($sformatf("unmapped reg 0x%02h", r), 0, rdata);
    end
    write_reg(REG_PROD_LO, ~p_keep[31:0]);
    write_reg(REG_PROD_HI, ~p_keep[63:32]);
    read_reg(REG_OPA, rdata);
    check_value("opa after stray writes", a_keep, rdata);
    read_reg(REG_OPB, rdata);
    check_value("opb after stray writes", b_keep, rdata);
    read_reg(REG_CTRL, rdata);
    check_value("status after stray writes", DONE_WORD, rdata);
    check_product(p_keep);

    $display("test passed");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/mul_pkg.sv
logic/mul_array_row.sv
logic/mul_array.sv
logic/wb_mul_regs.sv
logic/wb_mul_top.sv
test/tb_wb_mul.sv

// ==== Bender.yml ====
package:
  name: wb_mul

dependencies: {}

sources:
  # Package first, then the array, the bus slave and the top level.
  - files:
      - logic/mul_pkg.sv
      - logic/mul_array_row.sv
      - logic/mul_array.sv
      - logic/wb_mul_regs.sv
      - logic/wb_mul_top.sv

  # Testbench, top module tb_wb_mul.
  - target: test
    files:
      - test/tb_wb_mul.sv
